//--- Bender.yml
package:
  name: vdc_ramiface

sources:
  - files:
      - logic/vdc_pkg.sv
      - logic/vdc_cmd_if.sv
      - logic/vdc_regs_if.sv
      - logic/vdc_reg_decoder.sv
      - logic/vdc_ram_sequencer.sv
      - logic/vdc_ram.sv
      - logic/vdc_reg_readback.sv
      - logic/vdc_ramiface.sv
  - target: test
    files:
      - tb/vdc_ramiface_tb.sv

//--- logic/vdc_cmd_if.sv
// vdc command interface
// one decoded cpu request per pulse of req_valid, plus the
// busy flag returned by the ram sequencer

`timescale 1ns/1ps
`default_nettype none

interface vdc_cmd_if;

	logic              req_valid; // single-cycle pulse
	vdc_pkg::op_t      req_op;
	vdc_pkg::byte_t    req_data;
	logic              busy;

	modport decoder (
		output req_valid, req_op, req_data,
		input  busy
	);

	modport sequencer (
		input  req_valid, req_op, req_data,
		output busy
	);

endinterface

`default_nettype wire

//--- logic/vdc_pkg.sv
// vdc ram access package
// register numbers, data widths and the enums shared by the
// decoder, the ram sequencer and the readback

`default_nettype none

package vdc_pkg;

	typedef logic [7:0]  reg_num_t; // register index
	typedef logic [7:0]  byte_t;
	typedef logic [15:0] vaddr_t;   // video ram address

	localparam reg_num_t REG_UA_HI      = 8'd18;
	localparam reg_num_t REG_UA_LO      = 8'd19;
	localparam reg_num_t REG_WORD_COUNT = 8'd30;
	localparam reg_num_t REG_DATA       = 8'd31;
	localparam reg_num_t REG_BLOCK_HI   = 8'd32;
	localparam reg_num_t REG_BLOCK_LO   = 8'd33;

	localparam int RAM_WORDS = 65536;

	// decoded cpu requests
	typedef enum logic [2:0] {
		op_load_ua_hi, op_load_ua_lo, op_load_ba_hi, op_load_ba_lo,
		op_write_data, op_read_incr, op_block
	} op_t;

	typedef enum logic [3:0] {
		idle, read0, read1, incr0, incr1, write0, write1,
		fill0, fill1, fill2, copy0, copy1, copy2
	} seq_state_t;

endpackage

`default_nettype wire

//--- logic/vdc_ram.sv
// vdc video ram
// synchronous single-port byte ram with the 16 kB / 64 kB
// address remapping for the fitted and configured size

`timescale 1ns/1ps
`default_nettype none

module vdc_ram (
	input  wire             clk,
	input  wire             ram64k,  // 1 = 64 kB fitted
	input  wire             reg_ram, // 1 = 64 kB configured
	input  wire             we,
	input  vdc_pkg::vaddr_t addr,
	input  vdc_pkg::byte_t  wdata,
	output vdc_pkg::byte_t  rdata
);

	vdc_pkg::byte_t  mem [vdc_pkg::RAM_WORDS];
	vdc_pkg::vaddr_t maddr; // physical address

	always_comb begin
		if (ram64k && reg_ram)
			maddr = addr;
		else if (reg_ram)
			maddr = {1'b0, addr[14:9], 1'b0, addr[7:0]}; // only 16 kB fitted
		else
			maddr = {1'b0, addr[13:8], 1'b0, addr[7:0]}; // 16 kB layout
	end

	// read returns the old byte on a write cycle
	always_ff @(posedge clk) begin
		if (we)
			mem[maddr] <= wdata;
		rdata <= mem[maddr];
	end

endmodule

`default_nettype wire

//--- logic/vdc_ram_sequencer.sv
// vdc ram sequencer
// owns the update address, block address, word count and data
// registers; runs reads, writes, block fill and block copy on the
// video ram, one step per enabled clock

`timescale 1ns/1ps
`default_nettype none

module vdc_ram_sequencer (
	input  wire              clk,
	input  wire              reset,
	input  wire              enable,
	input  wire              reg_copy,
	vdc_cmd_if.sequencer     cmd,
	vdc_regs_if.sequencer    regs,
	output logic             ram_we,
	output vdc_pkg::vaddr_t  ram_addr,
	output vdc_pkg::byte_t   ram_wdata,
	input  vdc_pkg::byte_t   ram_rdata
);

	vdc_pkg::seq_state_t state;
	vdc_pkg::vaddr_t     ua;
	vdc_pkg::vaddr_t     ba;
	vdc_pkg::byte_t      wc;
	vdc_pkg::byte_t      da;
	vdc_pkg::byte_t      counter; // words left in a block op
	vdc_pkg::byte_t      latch;   // last byte written via reg 31
	logic                busy;
	logic                addr_fresh; // ram data still one clock behind ram_addr

	assign cmd.busy = busy;
	assign regs.ua  = ua;
	assign regs.ba  = ba;
	assign regs.wc  = wc;
	assign regs.da  = da;

	always_ff @(posedge clk) begin
		if (reset) begin
			state      <= vdc_pkg::idle;
			busy       <= 1'b0;
			ram_we     <= 1'b0;
			addr_fresh <= 1'b0;
			counter    <= '0;
			ua         <= '0;
			ba         <= '0;
			wc         <= '0;
			da         <= '0;
		end else begin
			addr_fresh <= 1'b0;
			if (enable)
				ram_we <= 1'b0;

			if (cmd.req_valid) begin
				case (cmd.req_op)
					vdc_pkg::op_load_ua_hi: begin
						ua[15:8] <= cmd.req_data;
						state    <= vdc_pkg::read0;
						busy     <= 1'b1;
					end
					vdc_pkg::op_load_ua_lo: begin
						ua[7:0] <= cmd.req_data;
						state   <= vdc_pkg::read0;
						busy    <= 1'b1;
					end
					vdc_pkg::op_load_ba_hi: ba[15:8] <= cmd.req_data; // no ram access
					vdc_pkg::op_load_ba_lo: ba[7:0]  <= cmd.req_data;
					vdc_pkg::op_write_data: begin
						latch <= cmd.req_data;
						state <= vdc_pkg::write0;
						busy  <= 1'b1;
					end
					vdc_pkg::op_read_incr: begin
						state <= vdc_pkg::incr0;
						busy  <= 1'b1;
					end
					default: begin // op_block
						wc      <= cmd.req_data;
						counter <= cmd.req_data;
						state   <= reg_copy ? vdc_pkg::copy0 : vdc_pkg::fill0;
						busy    <= 1'b1;
					end
				endcase
			end else if (enable) begin
				case (state)
					vdc_pkg::idle: busy <= 1'b0;

					vdc_pkg::read0: begin
						ram_addr   <= ua;
						addr_fresh <= 1'b1;
						state      <= vdc_pkg::read1;
					end
					vdc_pkg::read1: if (!addr_fresh) begin
						da    <= ram_rdata;
						state <= vdc_pkg::idle;
					end

					vdc_pkg::incr0: begin
						ram_addr   <= ua;
						addr_fresh <= 1'b1;
						state      <= vdc_pkg::incr1;
					end
					vdc_pkg::incr1: if (!addr_fresh) begin
						ua    <= ua + 16'd1;
						da    <= ram_rdata;
						state <= vdc_pkg::idle;
					end

					// write the latch at ua, then read back at ua + 1
					vdc_pkg::write0: begin
						ram_addr  <= ua;
						ram_wdata <= latch;
						ram_we    <= 1'b1;
						state     <= vdc_pkg::write1;
					end
					vdc_pkg::write1: begin
						ua    <= ua + 16'd1;
						state <= vdc_pkg::read0;
					end

					vdc_pkg::fill0: begin
						ram_addr  <= ua;
						ram_wdata <= latch;
						ram_we    <= 1'b1;
						state     <= vdc_pkg::fill1;
					end
					vdc_pkg::fill1: begin
						ua      <= ua + 16'd1;
						counter <= counter - 8'd1; // 0 wraps to 256 words
						state   <= vdc_pkg::fill2;
					end
					vdc_pkg::fill2: begin
						ram_addr <= ua;
						if (counter == 8'd0) begin
							state <= vdc_pkg::idle;
						end else begin
							ram_we <= 1'b1;
							state  <= vdc_pkg::fill1;
						end
					end

					// copy from ba to ua
					vdc_pkg::copy0: begin
						ram_addr   <= ba;
						addr_fresh <= 1'b1;
						state      <= vdc_pkg::copy1;
					end
					vdc_pkg::copy1: if (!addr_fresh) begin
						ram_wdata <= ram_rdata;
						ba        <= ba + 16'd1;
						counter   <= counter - 8'd1;
						ram_addr  <= ua;
						ram_we    <= 1'b1;
						state     <= vdc_pkg::copy2;
					end
					vdc_pkg::copy2: begin
						ua <= ua + 16'd1;
						if (counter == 8'd0) begin
							state <= vdc_pkg::idle;
						end else begin
							ram_addr   <= ba;
							addr_fresh <= 1'b1;
							state      <= vdc_pkg::copy1;
						end
					end

					default: state <= vdc_pkg::idle;
				endcase
			end
		end
	end

endmodule

`default_nettype wire

//--- logic/vdc_ramiface.sv
// vdc ram interface top level
// cpu register port, ram sequencer, video ram and readback

`timescale 1ns/1ps
`default_nettype none

module vdc_ramiface (
	input  wire               clk,
	input  wire               reset,
	input  wire               enable,
	input  wire               ram64k,
	input  wire               reg_ram,
	input  wire               reg_copy,
	input  wire               cs,
	input  wire               rs,
	input  wire               we,
	input  vdc_pkg::reg_num_t reg_a,
	input  vdc_pkg::byte_t    db_in,
	output vdc_pkg::byte_t    db_out,
	output logic              busy
);

	vdc_cmd_if  cmd_bus ();
	vdc_regs_if regs_bus ();

	logic            ram_we;
	vdc_pkg::vaddr_t ram_addr;
	vdc_pkg::byte_t  ram_wdata;
	vdc_pkg::byte_t  ram_rdata;

	assign busy = cmd_bus.busy;

	vdc_reg_decoder vdc_reg_decoder_i (
		.clk   (clk),
		.reset (reset),
		.cs    (cs),
		.rs    (rs),
		.we    (we),
		.reg_a (reg_a),
		.db_in (db_in),
		.cmd   (cmd_bus.decoder)
	);

	vdc_ram_sequencer vdc_ram_sequencer_i (
		.clk       (clk),
		.reset     (reset),
		.enable    (enable),
		.reg_copy  (reg_copy),
		.cmd       (cmd_bus.sequencer),
		.regs      (regs_bus.sequencer),
		.ram_we    (ram_we),
		.ram_addr  (ram_addr),
		.ram_wdata (ram_wdata),
		.ram_rdata (ram_rdata)
	);

	vdc_ram vdc_ram_i (
		.clk     (clk),
		.ram64k  (ram64k),
		.reg_ram (reg_ram),
		.we      (ram_we),
		.addr    (ram_addr),
		.wdata   (ram_wdata),
		.rdata   (ram_rdata)
	);

	vdc_reg_readback vdc_reg_readback_i (
		.rs     (rs),
		.reg_a  (reg_a),
		.busy   (cmd_bus.busy),
		.regs   (regs_bus.readback),
		.db_out (db_out)
	);

endmodule

`default_nettype wire

//--- logic/vdc_reg_decoder.sv
// vdc register port decoder
// turns cpu accesses on the data port into single-cycle requests
// for the ram sequencer; one request per cs assertion at most,
// nothing while the sequencer is busy

`timescale 1ns/1ps
`default_nettype none

module vdc_reg_decoder (
	input  wire               clk,
	input  wire               reset,
	input  wire               cs,
	input  wire               rs,
	input  wire               we,
	input  vdc_pkg::reg_num_t reg_a,
	input  vdc_pkg::byte_t    db_in,
	vdc_cmd_if.decoder        cmd
);

	logic         armed; // set again once cs has been low
	logic         hit;
	vdc_pkg::op_t op;

	always_comb begin
		hit = 1'b0;
		op  = vdc_pkg::op_read_incr;
		if (rs) begin
			if (we) begin
				hit = 1'b1;
				case (reg_a)
					vdc_pkg::REG_UA_HI:      op = vdc_pkg::op_load_ua_hi;
					vdc_pkg::REG_UA_LO:      op = vdc_pkg::op_load_ua_lo;
					vdc_pkg::REG_BLOCK_HI:   op = vdc_pkg::op_load_ba_hi;
					vdc_pkg::REG_BLOCK_LO:   op = vdc_pkg::op_load_ba_lo;
					vdc_pkg::REG_WORD_COUNT: op = vdc_pkg::op_block;
					vdc_pkg::REG_DATA:       op = vdc_pkg::op_write_data;
					default:                 hit = 1'b0;
				endcase
			end else if (reg_a == vdc_pkg::REG_DATA) begin
				hit = 1'b1; // data read advances ua
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			armed         <= 1'b1;
			cmd.req_valid <= 1'b0;
		end else begin
			cmd.req_valid <= 1'b0;
			if (!cs) begin
				armed <= 1'b1;
			end else if (armed) begin
				// the access is used up even when busy drops it
				armed <= 1'b0;
				if (hit && !cmd.busy) begin
					cmd.req_valid <= 1'b1;
					cmd.req_op    <= op;
					cmd.req_data  <= db_in;
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- logic/vdc_reg_readback.sv
// vdc register readback
// returns the selected ram interface register on the data port
// and the busy status on the status port

`timescale 1ns/1ps
`default_nettype none

module vdc_reg_readback (
	input  wire               rs,
	input  vdc_pkg::reg_num_t reg_a,
	input  wire               busy,
	vdc_regs_if.readback      regs,
	output vdc_pkg::byte_t    db_out
);

	always_comb begin
		db_out = '0;
		if (rs) begin
			case (reg_a)
				vdc_pkg::REG_UA_HI:      db_out = regs.ua[15:8];
				vdc_pkg::REG_UA_LO:      db_out = regs.ua[7:0];
				vdc_pkg::REG_WORD_COUNT: db_out = regs.wc;
				vdc_pkg::REG_DATA:       db_out = regs.da;
				vdc_pkg::REG_BLOCK_HI:   db_out = regs.ba[15:8];
				vdc_pkg::REG_BLOCK_LO:   db_out = regs.ba[7:0];
				default:                 db_out = '0; // other registers not here
			endcase
		end else begin
			db_out[7] = busy; // status byte
		end
	end

endmodule

`default_nettype wire

//--- logic/vdc_regs_if.sv
// vdc register view
// live update address, block address, word count and data
// register values for the cpu readback

`timescale 1ns/1ps
`default_nettype none

interface vdc_regs_if;

	vdc_pkg::vaddr_t ua; // update address
	vdc_pkg::vaddr_t ba; // block start address
	vdc_pkg::byte_t  wc; // word count
	vdc_pkg::byte_t  da; // data register

	modport sequencer (
		output ua, ba, wc, da
	);

	modport readback (
		input ua, ba, wc, da
	);

endinterface

`default_nettype wire

//--- sources.f
logic/vdc_pkg.sv
logic/vdc_cmd_if.sv
logic/vdc_regs_if.sv
logic/vdc_reg_decoder.sv
logic/vdc_ram_sequencer.sv
logic/vdc_ram.sv
logic/vdc_reg_readback.sv
logic/vdc_ramiface.sv
tb/vdc_ramiface_tb.sv

//--- tb/vdc_ramiface_tb.sv
// vdc ram interface testbench
// applies a table of cpu register accesses, waits for busy to fall
// and checks the readback against a reference model of the video ram

`timescale 1ns/1ps
`default_nettype none

module vdc_ramiface_tb;

	localparam int TIMEOUT = 4000;     // cycles per wait
	localparam int FROM_MODEL = -1;
	localparam logic [1:0] K_WR = 2'd0; // data port write
	localparam logic [1:0] K_RD = 2'd1; // data port read
	localparam logic [1:0] K_BP = 2'd2; // write and a dropped access while busy
	localparam logic [1:0] M64 = 2'b11;  // {ram64k, reg_ram}
	localparam logic [1:0] M16F = 2'b01;
	localparam logic [1:0] M16 = 2'b00;
	localparam logic [1:0] M16B = 2'b10;

	typedef struct packed {
		logic [1:0] kind;
		logic [7:0] rnum;
		logic [7:0] data;
		logic [1:0] mode;
		logic       copy;
		logic       gaps;
		logic [7:0] back;  // register read back afterwards
		logic       fixed;
		logic [7:0] exp;
	} step_t;

	logic              clk;
	logic              reset;
	logic              enable;
	logic              ram64k;
	logic              reg_ram;
	logic              reg_copy;
	logic              cs;
	logic              rs;
	logic              we;
	vdc_pkg::reg_num_t reg_a;
	vdc_pkg::byte_t    db_in;
	vdc_pkg::byte_t    db_out;
	logic              busy;

	logic [31:0]     lcg_state;
	logic            gaps;
	int              errors;
	int              timeouts;
	step_t           steps [$];
	vdc_pkg::byte_t  model_mem [vdc_pkg::RAM_WORDS]; // physical bytes
	vdc_pkg::vaddr_t m_ua;
	vdc_pkg::vaddr_t m_ba;
	vdc_pkg::byte_t  m_wc;
	vdc_pkg::byte_t  m_da;
	vdc_pkg::byte_t  m_latch;

	vdc_ramiface vdc_ramiface_i (
		.clk      (clk),
		.reset    (reset),
		.enable   (enable),
		.ram64k   (ram64k),
		.reg_ram  (reg_ram),
		.reg_copy (reg_copy),
		.cs       (cs),
		.rs       (rs),
		.we       (we),
		.reg_a    (reg_a),
		.db_in    (db_in),
		.db_out   (db_out),
		.busy     (busy)
	);

	always #5 clk = ~clk;

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	always @(negedge clk) begin
		if (gaps) begin
			lcg_state = lcg_next(lcg_state);
			enable <= lcg_state[16]; // random idle cycles
		end else begin
			enable <= 1'b1;
		end
	end

	// logical to physical address for the fitted and configured ram size
	function automatic vdc_pkg::vaddr_t map_addr(input vdc_pkg::vaddr_t a,
		input logic [1:0] m);
		if (m == M64)
			return a;
		if (m == M16F)
			return a & 16'h7eff;
		return ((a & 16'h3f00) << 1) | (a & 16'h00ff);
	endfunction

	function automatic vdc_pkg::byte_t model_reg(input vdc_pkg::reg_num_t r);
		case (r)
			8'd18:   return m_ua[15:8];
			8'd19:   return m_ua[7:0];
			8'd30:   return m_wc;
			8'd31:   return m_da;
			8'd32:   return m_ba[15:8];
			8'd33:   return m_ba[7:0];
			default: return 8'h00;
		endcase
	endfunction

	task automatic model_apply(input step_t s);
		int n;
		n = (s.data == 8'd0) ? 256 : int'(s.data);
		if (s.kind == K_RD) begin
			if (s.rnum == 8'd31) begin
				m_da = model_mem[map_addr(m_ua, s.mode)];
				m_ua = m_ua + 16'd1;
			end
		end else begin
			case (s.rnum)
				8'd18: m_ua[15:8] = s.data;
				8'd19: m_ua[7:0] = s.data;
				8'd32: m_ba[15:8] = s.data;
				8'd33: m_ba[7:0] = s.data;
				8'd31: begin
					m_latch = s.data;
					model_mem[map_addr(m_ua, s.mode)] = s.data;
					m_ua = m_ua + 16'd1;
				end
				8'd30: begin
					m_wc = s.data;
					for (int i = 0; i < n; i++) begin
						if (s.copy) begin
							model_mem[map_addr(m_ua, s.mode)] =
								model_mem[map_addr(m_ba, s.mode)];
							m_ba = m_ba + 16'd1;
						end else begin
							model_mem[map_addr(m_ua, s.mode)] = m_latch;
						end
						m_ua = m_ua + 16'd1;
					end
				end
				default: ;
			endcase
			if (s.rnum == 8'd18 || s.rnum == 8'd19 || s.rnum == 8'd31)
				m_da = model_mem[map_addr(m_ua, s.mode)]; // read after the update
		end
	endtask

	task automatic add_step(input logic [1:0] k, input logic [7:0] r, input logic [7:0] d,
		input logic [1:0] m, input logic c, input logic g, input logic [7:0] b, input int e);
		step_t s;
		s.kind = k;
		s.rnum = r;
		s.data = d;
		s.mode = m;
		s.copy = c;
		s.gaps = g;
		s.back = b;
		s.fixed = (e >= 0);
		s.exp = e[7:0];
		steps.push_back(s);
	endtask

	task automatic bus_access(input logic wr, input vdc_pkg::reg_num_t r,
		input vdc_pkg::byte_t d);
		@(negedge clk);
		cs = 1'b1;
		rs = 1'b1;
		we = wr;
		reg_a = r;
		db_in = d;
		@(negedge clk);
		cs = 1'b0;
		we = 1'b0;
		@(negedge clk); // request has reached the sequencer
	endtask

	task automatic wait_idle;
		int n;
		n = 0;
		while (busy && n < TIMEOUT) begin
			@(negedge clk);
			n++;
		end
		if (busy) begin
			$display("timeout at %0t: busy stayed high for %0d cycles", $time, n);
			timeouts++;
		end
	endtask

	task automatic check_byte(input vdc_pkg::byte_t exp, input string what);
		#1;
		assert (db_out === exp) else begin
			$display("CHECK FAILED at %0t: %s read %h, expected %h",
				$time, what, db_out, exp);
			errors++;
		end
	endtask

	task automatic run_step(input step_t s);
		vdc_pkg::byte_t exp;
		gaps = s.gaps;
		@(negedge clk);
		ram64k = s.mode[1];
		reg_ram = s.mode[0];
		reg_copy = s.copy;
		bus_access(s.kind != K_RD, s.rnum, s.data);
		if (s.kind == K_BP) begin
			rs = 1'b0;
			check_byte(8'h80, "status while busy");
			assert (busy === 1'b1) else begin
				$display("CHECK FAILED at %0t: busy low during a block fill", $time);
				errors++;
			end
			bus_access(1'b1, 8'd18, 8'haa); // dropped by the decoder
		end
		wait_idle();
		if (s.kind == K_BP) begin
			rs = 1'b0;
			check_byte(8'h00, "status when idle");
		end
		model_apply(s);
		exp = s.fixed ? s.exp : model_reg(s.back);
		@(negedge clk);
		rs = 1'b1;
		reg_a = s.back;
		check_byte(exp, $sformatf("register %0d", s.back));
	endtask

	task automatic build_steps;
		// fill 256 bytes at 0x1000 and do byte writes and reads
		add_step(K_WR, 8'd31, 8'ha5, M64, 0, 0, 8'd19, 8'h01);
		add_step(K_WR, 8'd18, 8'h10, M64, 0, 0, 8'd18, 8'h10);
		add_step(K_WR, 8'd19, 8'h00, M64, 0, 0, 8'd19, 8'h00);
		add_step(K_WR, 8'd30, 8'h00, M64, 0, 0, 8'd30, 8'h00);
		add_step(K_RD, 8'd18, 8'h00, M64, 0, 0, 8'd18, 8'h11);
		add_step(K_WR, 8'd18, 8'h10, M64, 0, 0, 8'd31, FROM_MODEL);
		add_step(K_WR, 8'd19, 8'hff, M64, 0, 0, 8'd31, 8'ha5);
		add_step(K_WR, 8'd19, 8'h20, M64, 0, 0, 8'd31, 8'ha5);
		add_step(K_WR, 8'd31, 8'h11, M64, 0, 0, 8'd31, FROM_MODEL);
		add_step(K_WR, 8'd31, 8'h22, M64, 0, 0, 8'd31, FROM_MODEL);
		add_step(K_WR, 8'd31, 8'h33, M64, 0, 0, 8'd31, FROM_MODEL);
		add_step(K_RD, 8'd19, 8'h00, M64, 0, 0, 8'd19, 8'h23);
		add_step(K_WR, 8'd19, 8'h20, M64, 0, 0, 8'd31, 8'h11);
		add_step(K_RD, 8'd31, 8'h00, M64, 0, 0, 8'd31, 8'h11);
		add_step(K_RD, 8'd31, 8'h00, M64, 0, 0, 8'd31, 8'h22);
		add_step(K_RD, 8'd31, 8'h00, M64, 0, 0, 8'd31, 8'h33);
		add_step(K_RD, 8'd31, 8'h00, M64, 0, 0, 8'd31, FROM_MODEL);
		add_step(K_RD, 8'd19, 8'h00, M64, 0, 0, 8'd19, 8'h24);
		// fill of 8 at 0x1040
		add_step(K_WR, 8'd31, 8'h5a, M64, 0, 0, 8'd31, FROM_MODEL);
		add_step(K_WR, 8'd19, 8'h40, M64, 0, 0, 8'd31, FROM_MODEL);
		add_step(K_WR, 8'd30, 8'h08, M64, 0, 0, 8'd30, 8'h08);
		add_step(K_RD, 8'd19, 8'h00, M64, 0, 0, 8'd19, 8'h48);
		add_step(K_WR, 8'd19, 8'h47, M64, 0, 0, 8'd31, 8'h5a);
		add_step(K_WR, 8'd19, 8'h48, M64, 0, 0, 8'd31, 8'ha5);
		// copy 4 bytes from 0x1020 to 0x2000
		add_step(K_WR, 8'd32, 8'h10, M64, 0, 0, 8'd32, 8'h10);
		add_step(K_WR, 8'd33, 8'h20, M64, 0, 0, 8'd33, 8'h20);
		add_step(K_WR, 8'd18, 8'h20, M64, 0, 0, 8'd18, 8'h20);
		add_step(K_WR, 8'd19, 8'h00, M64, 0, 0, 8'd19, 8'h00);
		add_step(K_WR, 8'd30, 8'h04, M64, 1, 0, 8'd30, 8'h04);
		add_step(K_RD, 8'd33, 8'h00, M64, 1, 0, 8'd33, 8'h24);
		add_step(K_RD, 8'd19, 8'h00, M64, 1, 0, 8'd19, 8'h04);
		add_step(K_WR, 8'd19, 8'h00, M64, 0, 0, 8'd31, 8'h11);
		add_step(K_WR, 8'd19, 8'h03, M64, 0, 0, 8'd31, 8'ha5);
		// address mapping with enable gaps
		add_step(K_WR, 8'd19, 8'h00, M16, 0, 1, 8'd18, 8'h20);
		add_step(K_WR, 8'd18, 8'h40, M16, 0, 1, 8'd31, 8'ha5);
		add_step(K_WR, 8'd31, 8'hc3, M16, 0, 1, 8'd19, 8'h01);
		add_step(K_WR, 8'd18, 8'h00, M16, 0, 1, 8'd19, 8'h01);
		add_step(K_WR, 8'd19, 8'h00, M16, 0, 1, 8'd31, 8'hc3);
		add_step(K_WR, 8'd18, 8'h40, M16B, 0, 1, 8'd31, 8'hc3);
		add_step(K_WR, 8'd18, 8'h80, M16F, 0, 1, 8'd31, 8'hc3);
		add_step(K_WR, 8'd31, 8'h7e, M16F, 0, 1, 8'd19, 8'h01);
		add_step(K_WR, 8'd19, 8'h00, M16F, 0, 1, 8'd31, 8'h7e);
		add_step(K_WR, 8'd18, 8'h01, M16F, 0, 1, 8'd31, 8'h7e);
		add_step(K_WR, 8'd18, 8'h00, M64, 0, 1, 8'd31, 8'h7e);
		add_step(K_RD, 8'd31, 8'h00, M64, 0, 1, 8'd19, 8'h01);
		// busy flag and dropped accesses
		add_step(K_WR, 8'd18, 8'h50, M64, 0, 0, 8'd18, 8'h50);
		add_step(K_WR, 8'd19, 8'h00, M64, 0, 0, 8'd19, 8'h00);
		add_step(K_BP, 8'd30, 8'h08, M64, 0, 0, 8'd30, 8'h08);
		add_step(K_RD, 8'd18, 8'h00, M64, 0, 0, 8'd18, 8'h50);
		add_step(K_RD, 8'd19, 8'h00, M64, 0, 0, 8'd19, 8'h08);
		add_step(K_WR, 8'd19, 8'h07, M64, 0, 0, 8'd31, 8'h7e);
	endtask

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		enable = 1'b1;
		ram64k = 1'b1;
		reg_ram = 1'b1;
		reg_copy = 1'b0;
		cs = 1'b0;
		rs = 1'b1;
		we = 1'b0;
		reg_a = '0;
		db_in = '0;
		gaps = 1'b0;
		lcg_state = 32'heae7_527f;
		errors = 0;
		timeouts = 0;
		m_ua = '0;
		m_ba = '0;
		m_wc = '0;
		m_da = '0;
		build_steps();
		repeat (4) @(negedge clk);
		reset = 1'b0;
		foreach (steps[i])
			run_step(steps[i]);
		$display("check errors: %0d, timeouts: %0d", errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

`default_nettype wire
